//--- flist.f
hdl/read_path_pkg.sv
hdl/read_capture_fifo.sv
hdl/read_latency_selector.sv
hdl/read_data_output.sv
hdl/oct_control.sv
hdl/read_datapath.sv
sim/tb_clock_gen.sv
sim/read_datapath_tb.sv

//--- hdl/oct_control.sv
//**************************************************************************
// Force OCT off window built from a history of the read enable
//**************************************************************************

`timescale 1ns/10ps

module oct_control #(
	parameter int MEM_T_RL = 8
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic rdata_en_full_i,
	output logic force_oct_off_o
);

	// Start and end of the termination window in AFI cycles after the enable
	// The window opens a little before the burst and closes a few cycles past it
	localparam int OCT_ON_DELAY  = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Enables of earlier edges, bit 0 being the one of the previous edge
	logic [OCT_OFF_DELAY-1:0] rdata_en_r;

	// Bit d is the enable seen d edges back, bit 0 is the current input
	logic [OCT_OFF_DELAY:0]   rdata_en_shifter;

	assign rdata_en_shifter = {rdata_en_r, rdata_en_full_i};

	//**************************************************************************
	// Termination window
	//**************************************************************************

	// Termination stays on while any enable lies inside the window, and the
	// force off request goes high only once the bus is quiet again
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r      <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_r      <= rdata_en_shifter[OCT_OFF_DELAY-1:0];
			force_oct_off_o <= ~(|rdata_en_shifter[OCT_OFF_DELAY:OCT_ON_DELAY]);
		end
	end

endmodule

//--- hdl/read_capture_fifo.sv
//**************************************************************************
// Read data resynchronization FIFO for one DQS group, written by the
// capture strobe and popped by the read latency logic
//**************************************************************************

`timescale 1ns/10ps

module read_capture_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                       pll_afi_clk,
	input  logic                       reset_n_afi_clk,
	input  logic                       fifo_reset_i,
	input  logic                       capture_valid_i,
	input  read_path_pkg::group_word_t capture_data_i,
	input  logic                       read_enable_i,
	output read_path_pkg::group_word_t read_data_o
);

	import read_path_pkg::*;

	// FIFO_DEPTH is a power of two, so the pointers wrap on their own
	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

	// Storage for the captured AFI cycles of this group
	group_word_t fifo_mem [FIFO_DEPTH];

	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;

	// One extra bit so that a full FIFO can be told apart from an empty one
	logic [ADDR_WIDTH:0]   fill_count;

	logic                  fifo_empty;
	logic                  fifo_full;
	logic                  do_push;
	logic                  do_pop;

	assign fifo_empty = (fill_count == '0);
	assign fifo_full  = (fill_count == FIFO_DEPTH[ADDR_WIDTH:0]);

	// A strobe into a full FIFO is dropped, and nothing is written while the
	// sequencer holds the FIFO in reset
	assign do_push = capture_valid_i & ~fifo_full & ~fifo_reset_i;

	// Popping an empty FIFO is ignored so the output word keeps its value
	assign do_pop  = read_enable_i & ~fifo_empty & ~fifo_reset_i;

	//**************************************************************************
	// Write side
	//**************************************************************************

	always_ff @(posedge pll_afi_clk)
	begin
		if (do_push)
		begin
			fifo_mem[wr_ptr] <= capture_data_i;
		end
	end

	//**************************************************************************
	// Pointers and fill count
	//**************************************************************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_count <= '0;
		end
		else if (fifo_reset_i)
		begin
			// Sequencer reset, the next pop returns the first word captured after it
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_count <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Push and pop in the same cycle leave the count unchanged
			fill_count <= fill_count + {{ADDR_WIDTH{1'b0}}, do_push}
				- {{ADDR_WIDTH{1'b0}}, do_pop};
		end
	end

	// The head word is registered on a pop and shows up one cycle later
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_data_o <= '0;
		end
		else if (do_pop)
		begin
			read_data_o <= fifo_mem[rd_ptr];
		end
	end

endmodule

//--- hdl/read_data_output.sv
//**************************************************************************
// Registered AFI read valid and the reordering of the FIFO words into
// time slot major and group major buses
//**************************************************************************

`timescale 1ns/10ps

module read_data_output #(
	parameter int NUM_DQS_GROUPS = 2
) (
	input  logic                                                  pll_afi_clk,
	input  logic                                                  reset_n_afi_clk,
	input  logic                                                  read_enable_i,
	input  read_path_pkg::group_word_t [NUM_DQS_GROUPS-1:0]       group_data_i,
	output logic [NUM_DQS_GROUPS*read_path_pkg::GROUP_WORD_WIDTH-1:0] afi_rdata_o,
	output logic [NUM_DQS_GROUPS*read_path_pkg::GROUP_WORD_WIDTH-1:0] phy_mux_read_fifo_q_o,
	output logic                                                  afi_rdata_valid_o
);

	import read_path_pkg::*;

	//**************************************************************************
	// Read valid
	//**************************************************************************

	// The FIFO words land one cycle after the pop, so the valid is delayed by
	// the same cycle to line up with them
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= 1'b0;
		end
		else
		begin
			afi_rdata_valid_o <= read_enable_i;
		end
	end

	//**************************************************************************
	// Data reordering
	//**************************************************************************

	// The controller wants the bus ordered by time slot and sub-ordered by
	// group, for two groups that is G1_T3 G0_T3 ... G1_T0 G0_T0 from the top
	// The sequencer reads it by group and sub-ordered by time slot, which is
	// the order the FIFO words already come in
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : gen_group
		for (genvar t = 0; t < SLOTS_PER_AFI; t++)
		begin : gen_slot
			dq_slot_t slot_data;

			// Slot t of group g as it sits in the FIFO word
			assign slot_data = group_data_i[g][t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];

			// Time slot major position for the AFI read data
			assign afi_rdata_o[(t*NUM_DQS_GROUPS+g)*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				slot_data;

			// Group major position for calibration reads
			assign phy_mux_read_fifo_q_o[g*GROUP_WORD_WIDTH+t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				slot_data;
		end
	end

endmodule

//--- hdl/read_datapath.sv
//**************************************************************************
// Read datapath top level with per group FIFOs, latency selection,
// output reordering and OCT control
//**************************************************************************

`timescale 1ns/10ps

module read_datapath #(
	parameter int NUM_DQS_GROUPS = 2,
	parameter int FIFO_DEPTH     = 8,
	parameter int MEM_T_RL       = 8
) (
	input  logic                                                  pll_afi_clk,
	input  logic                                                  reset_n_afi_clk,
	input  logic [NUM_DQS_GROUPS*read_path_pkg::GROUP_WORD_WIDTH-1:0] ddio_phy_dq_i,
	input  logic [NUM_DQS_GROUPS-1:0]                             capture_valid_i,
	input  logic [NUM_DQS_GROUPS-1:0]                             seq_read_fifo_reset_i,
	input  logic                                                  afi_rdata_en_full_i,
	input  read_path_pkg::latency_t                               seq_read_latency_counter_i,
	output logic [NUM_DQS_GROUPS*read_path_pkg::GROUP_WORD_WIDTH-1:0] afi_rdata_o,
	output logic [NUM_DQS_GROUPS*read_path_pkg::GROUP_WORD_WIDTH-1:0] phy_mux_read_fifo_q_o,
	output logic                                                  afi_rdata_valid_o,
	output logic                                                  force_oct_off_o
);

	import read_path_pkg::*;

	// Registered copy of the sequencer FIFO reset, one flop per group
	logic [NUM_DQS_GROUPS-1:0]         fifo_reset_r;

	// Pop strobe shared by all group FIFOs
	logic                              read_enable;

	// Head words of the group FIFOs, group 0 in the low word
	group_word_t [NUM_DQS_GROUPS-1:0] fifo_data;

	//**************************************************************************
	// Input side
	//**************************************************************************

	// The sequencer reset is retimed before it reaches the FIFO pointers
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			fifo_reset_r <= '0;
		end
		else
		begin
			fifo_reset_r <= seq_read_fifo_reset_i;
		end
	end

	// The captured bus is group major, so each group takes its own word
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : gen_read_fifo
		read_capture_fifo #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) u_read_capture_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.fifo_reset_i    (fifo_reset_r[g]),
			.capture_valid_i (capture_valid_i[g]),
			.capture_data_i  (ddio_phy_dq_i[g*GROUP_WORD_WIDTH +: GROUP_WORD_WIDTH]),
			.read_enable_i   (read_enable),
			.read_data_o     (fifo_data[g])
		);
	end

	//**************************************************************************
	// Latency processing
	//**************************************************************************

	read_latency_selector u_read_latency_selector (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i),
		.latency_count_i (seq_read_latency_counter_i),
		.read_enable_o   (read_enable)
	);

	oct_control #(
		.MEM_T_RL (MEM_T_RL)
	) u_oct_control (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o (force_oct_off_o)
	);

	//**************************************************************************
	// Output side
	//**************************************************************************

	read_data_output #(
		.NUM_DQS_GROUPS (NUM_DQS_GROUPS)
	) u_read_data_output (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.read_enable_i         (read_enable),
		.group_data_i          (fifo_data),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o)
	);

endmodule

//--- hdl/read_latency_selector.sv
//**************************************************************************
// Read latency shifter with a tap picked by the sequencer latency count
//**************************************************************************

`timescale 1ns/10ps

module read_latency_selector (
	input  logic                    pll_afi_clk,
	input  logic                    reset_n_afi_clk,
	input  logic                    rdata_en_full_i,
	input  read_path_pkg::latency_t latency_count_i,
	output logic                    read_enable_o
);

	import read_path_pkg::*;

	// Stage k holds the read enable that was sampled k edges before the
	// most recent one, so stage 0 is the enable of the edge just gone
	logic [MAX_READ_LATENCY-1:0] latency_shifter;

	//**************************************************************************
	// Latency shifter
	//**************************************************************************

	// The controller raises the full rate read enable for every AFI cycle of
	// data it expects back, and the shifter keeps a sliding record of it
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			// The oldest stage falls off the end as a new sample comes in
			latency_shifter <= {latency_shifter[MAX_READ_LATENCY-2:0], rdata_en_full_i};
		end
	end

	//**************************************************************************
	// Tap selection
	//**************************************************************************

	// During calibration the sequencer steps the count until the data read
	// back matches its pattern, which tunes the read latency of the interface
	// Tap L is high in the cycle that starts L edges after the sampling edge
	// A count of zero is not a legal setting
	assign read_enable_o = latency_shifter[latency_count_i];

	// The selected tap pops every group FIFO in the same cycle and is the
	// source of the read valid towards the controller

endmodule

//--- hdl/read_path_pkg.sv
//**************************************************************************
// Widths, types and constants shared by the read datapath modules
//**************************************************************************

package read_path_pkg;

	//**************************************************************************
	// Data widths
	//**************************************************************************

	// Number of DQ bits served by one DQS group
	localparam int DQ_GROUP_WIDTH = 8;

	// Half rate with double data rate gives four memory time slots per AFI cycle
	localparam int SLOTS_PER_AFI = 4;

	// One DQS group carries this many bits in one AFI cycle
	localparam int GROUP_WORD_WIDTH = DQ_GROUP_WIDTH * SLOTS_PER_AFI;

	// Data of one DQS group in a single memory time slot
	typedef logic [DQ_GROUP_WIDTH-1:0] dq_slot_t;

	// Data of one DQS group over a whole AFI cycle
	// Slot 0 sits in the low bits, slot 3 in the high bits
	typedef logic [GROUP_WORD_WIDTH-1:0] group_word_t;

	//**************************************************************************
	// Read latency
	//**************************************************************************

	// Width of the latency count written by the sequencer
	localparam int LATENCY_WIDTH = 4;

	// Read latency in AFI cycles as set by the sequencer during calibration
	typedef logic [LATENCY_WIDTH-1:0] latency_t;

	// The latency shifter holds one tap for every value the count can take
	// With a four bit count the shifter is sixteen stages long
	localparam int MAX_READ_LATENCY = 2 ** $bits(latency_t);

endpackage

//--- sim/read_datapath_tb.sv
//**************************************************************************
// Testbench for the read datapath with random traffic, a cycle based
// reference model, a single compare task and the final report
//**************************************************************************

`timescale 1ns/10ps

module read_datapath_tb;

	localparam int NUM_GROUPS       = 2;
	localparam int FIFO_DEPTH       = 8;
	localparam int MEM_T_RL         = 8;
	localparam int SLOT_WIDTH       = 8;
	localparam int SLOTS            = 4;
	localparam int WORD_WIDTH       = SLOT_WIDTH * SLOTS;
	localparam int BUS_WIDTH        = NUM_GROUPS * WORD_WIDTH;
	localparam int OCT_ON_DELAY     = 2;
	localparam int OCT_OFF_DELAY    = 7;
	localparam int MODEL_SLOTS      = 16;
	localparam int SETTLE_CYCLES    = 16;
	localparam int DRAIN_TIMEOUT    = 64;
	localparam int RESET_TIMEOUT_NS = 2000;

	logic                  clk;
	logic                  rst_n;
	logic [BUS_WIDTH-1:0]  ddio_phy_dq;
	logic [NUM_GROUPS-1:0] capture_valid;
	logic [NUM_GROUPS-1:0] seq_read_fifo_reset;
	logic                  afi_rdata_en_full;
	logic [3:0]            latency;
	logic [BUS_WIDTH-1:0]  afi_rdata;
	logic [BUS_WIDTH-1:0]  phy_mux_read_fifo_q;
	logic                  afi_rdata_valid;
	logic                  force_oct_off;

	integer seed;
	int     edge_num;
	int     error_count;
	int     check_count;
	int     test_count;
	int     test_errors;
	int     test_checks;
	logic   timed_out;
	string  current_test;

	// Edge numbers at which the read valid is due with the oldest at the front
	int exp_valid_q[$];

	// Bit d holds the enable that the DUT sampled d edges before the latest edge
	logic [OCT_OFF_DELAY:0] en_history;

	// Per group model of the captured words kept as ring buffers
	logic [WORD_WIDTH-1:0] model_mem [NUM_GROUPS][MODEL_SLOTS];
	int                    model_head [NUM_GROUPS];
	int                    model_count [NUM_GROUPS];

	tb_clock_gen #(
		.CLK_PERIOD_NS (40),
		.RESET_CYCLES  (10)
	) u_tb_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	read_datapath #(
		.NUM_DQS_GROUPS (NUM_GROUPS),
		.FIFO_DEPTH     (FIFO_DEPTH),
		.MEM_T_RL       (MEM_T_RL)
	) u_read_datapath (
		.pll_afi_clk                (clk),
		.reset_n_afi_clk            (rst_n),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.capture_valid_i            (capture_valid),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.seq_read_latency_counter_i (latency),
		.afi_rdata_o                (afi_rdata),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off)
	);

	//**************************************************************************
	// Compare and bookkeeping
	//**************************************************************************

	task automatic check_value(input string what, input logic [BUS_WIDTH-1:0] expected,
		input logic [BUS_WIDTH-1:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("error %s %s expected %h actual %h", current_test, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors  = error_count;
		test_checks  = check_count;
		test_count++;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", current_test,
			check_count - test_checks, error_count - test_errors);
	endtask

	function automatic logic percent_hit(input int pct);
		percent_hit = ($unsigned($random(seed)) % 100) < pct;
	endfunction

	//**************************************************************************
	// Reference model
	//**************************************************************************

	task automatic model_push(input int g, input logic [WORD_WIDTH-1:0] word);
		model_mem[g][(model_head[g] + model_count[g]) % MODEL_SLOTS] = word;
		model_count[g]++;
	endtask

	task automatic model_flush(input int g);
		model_count[g] = 0;
	endtask

	// Outputs are looked at half a period after the rising edge when they have
	// settled and are compared with what the model predicts for that edge
	task automatic check_outputs();
		logic                  exp_valid;
		logic                  exp_oct;
		logic [WORD_WIDTH-1:0] head_word;
		logic [BUS_WIDTH-1:0]  exp_afi;
		logic [BUS_WIDTH-1:0]  exp_seq;
		int                    g;
		int                    t;
		exp_valid = 1'b0;
		if (exp_valid_q.size() > 0)
		begin
			if (exp_valid_q[0] == edge_num)
			begin
				exp_valid = 1'b1;
				void'(exp_valid_q.pop_front());
			end
		end
		check_value("afi_rdata_valid", exp_valid, afi_rdata_valid);
		if (exp_valid)
		begin
			exp_afi = '0;
			exp_seq = '0;
			for (g = 0; g < NUM_GROUPS; g++)
			begin
				head_word = model_mem[g][model_head[g]];
				// The controller bus is ordered by time slot and then by group
				for (t = 0; t < SLOTS; t++)
				begin
					exp_afi[(t*NUM_GROUPS+g)*SLOT_WIDTH +: SLOT_WIDTH] =
						head_word[t*SLOT_WIDTH +: SLOT_WIDTH];
				end
				// Sequencer bus is the captured bus as it came in
				exp_seq[g*WORD_WIDTH +: WORD_WIDTH] = head_word;
				model_head[g]  = (model_head[g] + 1) % MODEL_SLOTS;
				model_count[g] = model_count[g] - 1;
			end
			check_value("afi_rdata", exp_afi, afi_rdata);
			check_value("phy_mux_read_fifo_q", exp_seq, phy_mux_read_fifo_q);
		end
		// Termination must be left on while an enable lies 2 to 7 edges back
		exp_oct = ~(|en_history[OCT_OFF_DELAY:OCT_ON_DELAY]);
		check_value("force_oct_off", exp_oct, force_oct_off);
	endtask

	//**************************************************************************
	// Stimulus
	//**************************************************************************

	task automatic clock_step();
		@(negedge clk);
		edge_num++;
		check_outputs();
		// The sequencer FIFO reset is a single cycle pulse
		seq_read_fifo_reset = '0;
	endtask

	// A read is only issued when every group holds a word not yet claimed
	task automatic drive_enable(input logic req);
		logic avail;
		int   g;
		avail = req;
		for (g = 0; g < NUM_GROUPS; g++)
		begin
			if (model_count[g] <= exp_valid_q.size())
			begin
				avail = 1'b0;
			end
		end
		afi_rdata_en_full = avail;
		// The DUT samples the enable at the next edge and the valid follows
		// latency plus one edges after it
		if (avail)
		begin
			exp_valid_q.push_back(edge_num + 2 + int'(latency));
		end
		en_history = {en_history[OCT_OFF_DELAY-1:0], avail};
	endtask

	// Group select below zero lets every group capture
	task automatic drive_captures(input int cap_pct, input int only_group);
		logic [WORD_WIDTH-1:0] word;
		logic                  hit;
		int                    g;
		for (g = 0; g < NUM_GROUPS; g++)
		begin
			word = $random(seed);
			hit  = percent_hit(cap_pct);
			ddio_phy_dq[g*WORD_WIDTH +: WORD_WIDTH] = word;
			if (hit && (only_group < 0 || only_group == g) && model_count[g] < FIFO_DEPTH)
			begin
				capture_valid[g] = 1'b1;
				model_push(g, word);
			end
			else
			begin
				capture_valid[g] = 1'b0;
			end
		end
	endtask

	task automatic traffic_cycle(input int rd_pct, input int cap_pct);
		clock_step();
		drive_enable(percent_hit(rd_pct));
		drive_captures(cap_pct, -1);
	endtask

	task automatic idle_cycle();
		clock_step();
		drive_enable(1'b0);
		drive_captures(0, -1);
	endtask

	// Lets all issued reads come back and then clears the latency shifter so
	// the latency count can change safely
	task automatic drain_reads();
		int waited;
		waited = 0;
		while (exp_valid_q.size() > 0 && waited < DRAIN_TIMEOUT)
		begin
			idle_cycle();
			waited++;
		end
		if (exp_valid_q.size() > 0)
		begin
			$display("timeout: read valid still pending after %0d cycles", DRAIN_TIMEOUT);
			timed_out = 1'b1;
		end
		repeat (SETTLE_CYCLES) idle_cycle();
	endtask

	//**************************************************************************
	// Tests
	//**************************************************************************

	task automatic run_reset_test();
		int waited_ns;
		start_test("reset_state");
		waited_ns = 0;
		while (rst_n !== 1'b1 && waited_ns < RESET_TIMEOUT_NS)
		begin
			#1;
			waited_ns++;
		end
		if (rst_n !== 1'b1)
		begin
			$display("timeout: reset was never released");
			timed_out = 1'b1;
		end
		else
		begin
			check_value("afi_rdata_valid", 1'b0, afi_rdata_valid);
			check_value("force_oct_off", 1'b0, force_oct_off);
		end
		end_test();
	endtask

	task automatic run_latency_test();
		int round;
		start_test("read_latency");
		for (round = 0; round < 8; round++)
		begin
			drain_reads();
			// The first two rounds take the shortest and the longest latency
			if (round == 0)
				latency = 4'd1;
			else if (round == 1)
				latency = 4'd15;
			else
				latency = 1 + ($unsigned($random(seed)) % 15);
			repeat (40) traffic_cycle(50, 80);
		end
		drain_reads();
		end_test();
	endtask

	task automatic run_data_order_test();
		start_test("data_order");
		latency = 1 + ($unsigned($random(seed)) % 15);
		repeat (150) traffic_cycle(40, 50);
		drain_reads();
		end_test();
	endtask

	task automatic run_fifo_reset_test();
		int rep;
		int g;
		start_test("fifo_reset");
		for (rep = 0; rep < 4; rep++)
		begin
			drain_reads();
			g = $unsigned($random(seed)) % NUM_GROUPS;
			// Leave stale words in the group that is about to be reset
			repeat (3)
			begin
				clock_step();
				drive_enable(1'b0);
				drive_captures(100, g);
			end
			clock_step();
			drive_enable(1'b0);
			drive_captures(0, -1);
			seq_read_fifo_reset[g] = 1'b1;
			// The retimed reset clears the pointers one edge after sampling
			idle_cycle();
			idle_cycle();
			model_flush(g);
			repeat (40) traffic_cycle(40, 60);
		end
		drain_reads();
		end_test();
	endtask

	task automatic run_oct_test();
		int burst;
		int len;
		int gap;
		start_test("oct_window");
		latency = 1 + ($unsigned($random(seed)) % 15);
		repeat (6) traffic_cycle(0, 100);
		for (burst = 0; burst < 16; burst++)
		begin
			if (percent_hit(50))
				len = 1;
			else
				len = 2 + ($unsigned($random(seed)) % 5);
			repeat (len) traffic_cycle(100, 100);
			gap = $unsigned($random(seed)) % 10;
			repeat (gap) traffic_cycle(0, 70);
		end
		drain_reads();
		end_test();
	endtask

	//**************************************************************************
	// Main sequence
	//**************************************************************************

	initial
	begin
		int g;
		seed                = 32'hfbe9_49ef;
		ddio_phy_dq         = '0;
		capture_valid       = '0;
		seq_read_fifo_reset = '0;
		afi_rdata_en_full   = 1'b0;
		latency             = 4'd1;
		edge_num            = 0;
		error_count         = 0;
		check_count         = 0;
		test_count          = 0;
		timed_out           = 1'b0;
		en_history          = '0;
		for (g = 0; g < NUM_GROUPS; g++)
		begin
			model_head[g]  = 0;
			model_count[g] = 0;
		end

		run_reset_test();
		if (!timed_out)
			run_latency_test();
		if (!timed_out)
			run_data_order_test();
		if (!timed_out)
			run_fifo_reset_test();
		if (!timed_out)
			run_oct_test();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- sim/tb_clock_gen.sv
//**************************************************************************
// Testbench clock and active low reset generator
//**************************************************************************

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int CLK_PERIOD_NS = 40,
	parameter int RESET_CYCLES  = 10
) (
	output logic clk_o,
	output logic rst_n_o
);

	// Free running AFI clock
	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	// Reset is held for a number of rising edges and let go on a falling edge,
	// which leaves half a period to look at the reset state
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule
